//--- Bender.yml
package:
  name: seq_multiplier

sources:
  - mulTypesPkg.sv
  - mulCtrlPkg.sv
  - mulController.sv
  - mulDatapath.sv
  - resultBuffer.sv
  - multiplierTop.sv
  - target: test
    files:
      - productChecker.sv
      - multiplierTb.sv

//--- flist.f
mulTypesPkg.sv
mulCtrlPkg.sv
mulController.sv
mulDatapath.sv
resultBuffer.sv
multiplierTop.sv
productChecker.sv
multiplierTb.sv

//--- mulController.sv
// add-and-shift sequencer for a signed multiply of Width-bit operands
// Width must be 2 or more; the input handshake is four-phase and the operands
// are taken on the edge that leaves IDLE, so they must be stable with inReq
`timescale 1ns/1ps

module mulController
  import mulCtrlPkg::*;
#(
  parameter int Width
) (
  input  logic     CLk,
  input  logic     reset,
  input  logic     inReq,
  input  logic     multiplierLsb,
  input  logic     full,
  output logic     inAck,
  output mulCtrl_t ctrl,
  output logic     pushValid
);

  localparam int CountW = $clog2(Width);
  localparam logic [CountW-1:0] LastStep = CountW'(Width - 2);  // last ITERATE cycle

  mulState_t state;
  mulState_t nextState;
  logic [CountW-1:0] bitCount;
  logic handshakeDone;

  // request/ack pair has returned to zero, or a new request is already waiting
  assign handshakeDone = !inAck || !inReq;
  assign pushValid = (state == PUSH) && !full && handshakeDone;

  always_comb
  begin
    ctrl = '0;
    ctrl.load = (state == IDLE) && inReq;
    ctrl.clear = (state == CLEAR);
    ctrl.addStep = (state == ITERATE) && multiplierLsb;
    ctrl.subStep = (state == FINAL) && multiplierLsb;  // sign bit has negative weight
    ctrl.shift = (state == ITERATE) || (state == FINAL);
  end

  always_comb
  begin
    nextState = state;
    unique case (state)
      IDLE:
      begin
        if (inReq)
          nextState = LOAD;
      end
      LOAD:
        nextState = CLEAR;
      CLEAR:
        nextState = ITERATE;
      ITERATE:
      begin
        if (bitCount == LastStep)
          nextState = FINAL;
      end
      FINAL:
        nextState = PUSH;
      PUSH:
      begin
        if (pushValid)
          nextState = IDLE;
      end
      default:
        nextState = IDLE;
    endcase
  end

  always_ff @(posedge CLk)
  begin
    if (reset)
    begin
      state <= IDLE;
      bitCount <= '0;
      inAck <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (state == ITERATE)
        bitCount <= bitCount + CountW'(1);
      else
        bitCount <= '0;  // ready for the next operand
      // ack rises with LOAD and falls once the request has been withdrawn
      if (ctrl.load)
        inAck <= 1'b1;
      else if ((state == PUSH) && !inReq)
        inAck <= 1'b0;
    end
  end

endmodule

//--- mulCtrlPkg.sv
// controller state encoding and the strobes it sends to the datapath
// strobes are one-cycle level signals, sampled on the next rising edge
package mulCtrlPkg;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    CLEAR,
    ITERATE,
    FINAL,
    PUSH
  } mulState_t;

  // addStep and subStep are mutually exclusive and always come with shift
  typedef struct packed {
    logic load;     // register operands
    logic clear;    // zero accumulator and sign bit
    logic addStep;  // add multiplicand into accumulator
    logic subStep;  // subtract multiplicand, last bit only
    logic shift;    // arithmetic right shift of the product register
  } mulCtrl_t;

endpackage

//--- mulDatapath.sv
// product register and adder for the add-and-shift multiplier
// works on the low Width bits of each operand field; the product is returned
// sign-extended to the full product word
`timescale 1ns/1ps

module mulDatapath
  import mulTypesPkg::*, mulCtrlPkg::*;
#(
  parameter int Width
) (
  input  logic         CLk,
  input  logic         reset,
  input  mulCtrl_t     ctrl,
  input  operandPair_t operands,
  output logic         multiplierLsb,
  output result_t      result
);

  localparam logic [Width-1:0] MostNeg = {1'b1, {(Width-1){1'b0}}};

  logic [Width-1:0] multiplicand;
  product_u prodReg;
  logic signExt;     // sign of accumulator beyond its top bit
  logic fullWidth;
  logic [Width-1:0] accW;
  logic [Width-1:0] mplrW;
  logic [Width-1:0] opMcand;
  logic [Width-1:0] opMplr;
  logic [Width:0] addend;
  logic [Width:0] sum;
  logic signed [2*Width-1:0] productW;

  assign accW = prodReg.halves.accumulator[Width-1:0];
  assign mplrW = prodReg.halves.multiplier[Width-1:0];
  assign opMcand = operands.multiplicand[Width-1:0];
  assign opMplr = operands.multiplier[Width-1:0];
  assign multiplierLsb = mplrW[0];

  assign addend = {multiplicand[Width-1], multiplicand};  // sign-extend by one bit

  always_comb
  begin
    if (ctrl.subStep)
      sum = {signExt, accW} - addend;
    else if (ctrl.addStep)
      sum = {signExt, accW} + addend;
    else
      sum = {signExt, accW};  // shift only
  end

  always_ff @(posedge CLk)
  begin
    if (ctrl.load)
      multiplicand <= opMcand;
  end

  always_ff @(posedge CLk)
  begin
    if (reset)
    begin
      prodReg <= '0;
      signExt <= 1'b0;
      fullWidth <= 1'b0;
    end
    else if (ctrl.load)
    begin
      prodReg.halves.multiplier <= DefaultWidth'(opMplr);
      fullWidth <= (opMcand == MostNeg) && (opMplr == MostNeg);
    end
    else if (ctrl.clear)
    begin
      prodReg.halves.accumulator <= '0;
      signExt <= 1'b0;
    end
    else if (ctrl.shift)
    begin
      // sum goes in first, then the whole register moves right by one
      signExt <= sum[Width];
      prodReg.halves.accumulator <= DefaultWidth'(sum[Width:1]);
      prodReg.halves.multiplier <= DefaultWidth'({sum[0], mplrW[Width-1:1]});
    end
  end

  // after the last step the two halves form the signed product
  assign productW = {accW, mplrW};

  always_comb
  begin
    result.product.word = (2*DefaultWidth)'(productW);
    result.fullWidth = fullWidth;
  end

  oneArithOp: assert property (@(posedge CLk) disable iff (reset)
    !(ctrl.addStep && ctrl.subStep))
    else $error("add and subtract requested in the same step");

endmodule

//--- mulTypesPkg.sv
// data types shared by the datapath, the result buffer and the top level
// struct fields are sized at DefaultWidth; a narrower Width uses the low bits
// of each field, so operands must be sign-extended into the fields by the sender
package mulTypesPkg;

  localparam int DefaultWidth = 8;  // widest operand the types can hold

  // operand pair as offered on the input port
  typedef struct packed {
    logic signed [DefaultWidth-1:0] multiplicand;
    logic signed [DefaultWidth-1:0] multiplier;
  } operandPair_t;

  // product register split as it is used while iterating
  typedef struct packed {
    logic [DefaultWidth-1:0] accumulator;  // upper half, receives the partial sums
    logic [DefaultWidth-1:0] multiplier;   // lower half, shifted out one bit per step
  } productHalves_t;

  // same bits read either as two halves or as one finished product
  typedef union packed {
    productHalves_t halves;
    logic signed [2*DefaultWidth-1:0] word;
  } product_u;

  // one finished result as stored in the buffer and sent downstream
  typedef struct packed {
    product_u product;
    logic fullWidth;  // set only for most-negative times most-negative
  } result_t;

endpackage

//--- multiplierTb.sv
// testbench for the sequential signed multiplier at the default width
// corner rows plus seeded random rows; acks are withheld for one stretch so
// that the result buffer fills and the input port must hold off
`timescale 1ns/1ps

module multiplierTb
  import mulTypesPkg::*;
();

  localparam int Width = DefaultWidth;
  localparam int Depth = 4;
  localparam int HalfPeriod = 20;
  localparam int NumFixed = 12;
  localparam int NumRandom = 12;
  localparam int NumRows = NumFixed + NumRandom;
  localparam int StallStart = NumFixed;              // first row with acks withheld
  localparam int StallRow = StallStart + Depth + 1;  // this one must wait
  localparam int StallCycles = 4 * (Width + 4);
  localparam int DelayBudget = 30;                   // largest gap plus largest ack delay
  localparam int TimeoutCycles =
    16 + StallCycles + NumRows * (Width + 1 + DelayBudget + 20);
  localparam logic signed [DefaultWidth-1:0] MostNeg = {1'b1, {(DefaultWidth-1){1'b0}}};

  typedef struct packed {
    operandPair_t operands;
    logic [3:0] gap;       // idle cycles before the request
    logic [3:0] ackDelay;  // cycles before this row's product is acked
  } stimRow_t;

  logic CLk;
  logic reset;
  logic inReq;
  operandPair_t inData;
  logic outAck;
  logic inAck;
  logic outReq;
  result_t outData;
  logic holdAcks;
  stimRow_t rows[$];
  integer seed;
  int rowIdx;
  int rowsSent;
  int ackCount;
  int tbErrors;
  int checkedCount;
  int passCount;
  int errorCount;

  multiplierTop #(
    .Width(Width),
    .Depth(Depth)
  ) dut_i (
    .CLk(CLk), .reset(reset), .inReq(inReq), .inData(inData), .outAck(outAck),
    .inAck(inAck), .outReq(outReq), .outData(outData)
  );

  productChecker checker_i (
    .CLk(CLk), .reset(reset), .inReq(inReq), .inAck(inAck), .outReq(outReq),
    .outAck(outAck), .outData(outData), .checkedCount(checkedCount),
    .passCount(passCount), .errorCount(errorCount)
  );

  initial
  begin
    CLk = 1'b0;
    forever #HalfPeriod CLk = ~CLk;
  end

  function automatic result_t expectedResult(input operandPair_t ops);
    result_t res;
    int full;
    full = int'($signed(ops.multiplicand)) * int'($signed(ops.multiplier));
    res.product.word = (2*DefaultWidth)'(full);
    res.fullWidth = (ops.multiplicand == MostNeg) && (ops.multiplier == MostNeg);
    return res;
  endfunction

  task automatic addRow(input int mcand, input int mplr, input int gap, input int ackDelay);
    stimRow_t row;
    row.operands.multiplicand = DefaultWidth'(mcand);
    row.operands.multiplier = DefaultWidth'(mplr);
    row.gap = 4'(gap);
    row.ackDelay = 4'(ackDelay);
    rows.push_back(row);
  endtask

  task automatic buildTable();
    int i;
    int mcand;
    int mplr;
    int gap;
    int ackDelay;
    addRow(0, 37, 0, 0);
    addRow(-90, 0, 2, 1);
    addRow(1, -1, 0, 3);
    addRow(-1, -1, 5, 0);
    addRow(127, 127, 1, 7);
    addRow(-128, 127, 0, 2);
    addRow(127, -128, 3, 0);
    addRow(-128, -128, 0, 1);  // only product that needs all 16 bits
    addRow(85, -86, 7, 4);     // 0x55 x 0xAA
    addRow(-86, -86, 0, 0);
    addRow(85, 85, 2, 9);
    addRow(-128, 1, 1, 2);
    for (i = 0; i < NumRandom; i++)
    begin
      mcand = $random(seed);
      mplr = $random(seed);
      gap = $random(seed);
      ackDelay = $random(seed);
      addRow(mcand, mplr, gap & 7, ackDelay & 15);
    end
  endtask

  // four-phase offer of one row, starting right after a rising edge
  task automatic applyRow(input int idx);
    stimRow_t row;
    logic stallBroken;
    row = rows[idx];
    stallBroken = 1'b0;
    repeat (row.gap) @(posedge CLk);
    checker_i.addExpected(row.operands, expectedResult(row.operands));
    inData <= row.operands;
    inReq <= 1'b1;
    rowsSent++;
    if (idx == StallRow)
    begin
      // buffer full and controller holding a product, so no ack may come
      repeat (StallCycles)
      begin
        @(posedge CLk);
        if (inAck)
          stallBroken = 1'b1;
      end
      if (stallBroken)
      begin
        $display("back-pressure failed: inAck rose while the result buffer was full");
        tbErrors++;
      end
      else
        $display("back-pressure held: %0d operands accepted, next one kept waiting", Depth + 1);
      holdAcks <= 1'b0;
    end
    do @(posedge CLk); while (!inAck);
    inReq <= 1'b0;
    do @(posedge CLk); while (inAck);
  endtask

  task automatic waitForDrain();
    while (ackCount != rowsSent)
      @(posedge CLk);
  endtask

  // output side: ack each product after its row's delay unless acks are held
  initial
  begin
    ackCount = 0;
    @(negedge reset);
    forever
    begin
      @(posedge CLk);
      if (outReq && !holdAcks)
      begin
        if (ackCount < NumRows)
          repeat (rows[ackCount].ackDelay) @(posedge CLk);
        outAck <= 1'b1;
        do @(posedge CLk); while (outReq);
        outAck <= 1'b0;
        ackCount++;
      end
    end
  end

  initial
  begin
    repeat (TimeoutCycles) @(posedge CLk);
    $display("run timed out after %0d cycles with %0d of %0d results outstanding",
             TimeoutCycles, NumRows - checkedCount, NumRows);
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    reset = 1'b1;
    inReq = 1'b0;
    inData = '0;
    outAck = 1'b0;
    holdAcks = 1'b0;
    rowsSent = 0;
    tbErrors = 0;
    seed = 19620;
    buildTable();
    repeat (16) @(posedge CLk);
    reset <= 1'b0;
    @(posedge CLk);
    if (inAck || outReq)
    begin
      $display("inAck or outReq was not low after reset");
      tbErrors++;
    end
    for (rowIdx = 0; rowIdx < NumRows; rowIdx++)
    begin
      if (rowIdx == StallStart)
      begin
        waitForDrain();
        holdAcks <= 1'b1;
      end
      applyRow(rowIdx);
    end
    waitForDrain();
    repeat (4) @(posedge CLk);
    if (checkedCount != NumRows)
    begin
      $display("expected %0d products but %0d were checked", NumRows, checkedCount);
      tbErrors++;
    end
    $display("%0d products checked, %0d passed, %0d checker errors, %0d testbench errors",
             checkedCount, passCount, errorCount, tbErrors);
    if ((errorCount == 0) && (tbErrors == 0))
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- multiplierTop.sv
// sequential signed multiplier with four-phase input and output ports
// Width is limited to 2..DefaultWidth; narrower operands sit sign-extended in
// the operand fields, and products come out sign-extended in the product word
`timescale 1ns/1ps

module multiplierTop
  import mulTypesPkg::*, mulCtrlPkg::*;
#(
  parameter int Width = DefaultWidth,
  parameter int Depth = 4
) (
  input  logic         CLk,
  input  logic         reset,
  input  logic         inReq,
  input  operandPair_t inData,
  input  logic         outAck,
  output logic         inAck,
  output logic         outReq,
  output result_t      outData
);

  mulCtrl_t ctrl;
  logic multiplierLsb;
  logic pushValid;
  logic full;
  result_t result;

  mulController #(
    .Width(Width)
  ) controller_i (
    .CLk          (CLk),
    .reset        (reset),
    .inReq        (inReq),
    .multiplierLsb(multiplierLsb),
    .full         (full),
    .inAck        (inAck),
    .ctrl         (ctrl),
    .pushValid    (pushValid)
  );

  mulDatapath #(
    .Width(Width)
  ) datapath_i (
    .CLk          (CLk),
    .reset        (reset),
    .ctrl         (ctrl),
    .operands     (inData),  // sampled on the load strobe
    .multiplierLsb(multiplierLsb),
    .result       (result)
  );

  resultBuffer #(
    .Width(Width),
    .Depth(Depth)
  ) buffer_i (
    .CLk      (CLk),
    .reset    (reset),
    .pushValid(pushValid),
    .pushData (result),
    .outAck   (outAck),
    .full     (full),
    .outReq   (outReq),
    .outData  (outData)
  );

  widthInRange: assert property (@(posedge CLk) (Width >= 2) && (Width <= DefaultWidth))
    else $error("operand width %0d outside 2..%0d", Width, DefaultWidth);

endmodule

//--- productChecker.sv
// compares each product leaving the multiplier with the expected order and
// watches both req/ack ports; a product is checked on the rise of outAck
`timescale 1ns/1ps

module productChecker
  import mulTypesPkg::*;
(
  input  logic    CLk,
  input  logic    reset,
  input  logic    inReq,
  input  logic    inAck,
  input  logic    outReq,
  input  logic    outAck,
  input  result_t outData,
  output int      checkedCount,
  output int      passCount,
  output int      errorCount
);

  operandPair_t opsQ[$];  // operands in the order they were offered
  result_t expectQ[$];
  operandPair_t ops;
  result_t expected;
  logic prevInReq = 1'b0;
  logic prevInAck = 1'b0;
  logic prevOutReq = 1'b0;
  logic prevOutAck = 1'b0;
  result_t prevOutData = '0;

  initial
  begin
    checkedCount = 0;
    passCount = 0;
    errorCount = 0;
  end

  task automatic addExpected(input operandPair_t pair, input result_t res);
    opsQ.push_back(pair);
    expectQ.push_back(res);
  endtask

  task automatic protocolError(input string what);
    $display("protocol error at %0t: %s", $time, what);
    errorCount++;
  endtask

  task automatic compareHead();
    logic ok;
    if (expectQ.size() == 0)
      protocolError("outAck rose with no product expected, a product was duplicated");
    else
    begin
      ops = opsQ.pop_front();
      expected = expectQ.pop_front();
      checkedCount++;
      ok = 1'b1;
      if (outData.product.word !== expected.product.word)
      begin
        $display("MISMATCH at %0t: outData.product.word expected %0d, got %0d", $time,
                 $signed(expected.product.word), $signed(outData.product.word));
        ok = 1'b0;
      end
      if (outData.fullWidth !== expected.fullWidth)
      begin
        $display("MISMATCH at %0t: outData.fullWidth expected %0b, got %0b", $time,
                 expected.fullWidth, outData.fullWidth);
        ok = 1'b0;
      end
      if (ok)
      begin
        passCount++;
        $display("test %0d passed: %0d x %0d = %0d", checkedCount, $signed(ops.multiplicand),
                 $signed(ops.multiplier), $signed(outData.product.word));
      end
      else
        errorCount++;
    end
  endtask

  // values are sampled before the edge updates them
  always @(posedge CLk)
  begin
    if (!reset)
    begin
      if (inAck && !prevInAck && !prevInReq)
        protocolError("inAck rose without a pending inReq");
      if (!inAck && prevInAck && prevInReq)
        protocolError("inAck fell while inReq was still high");
      if (prevOutReq && outReq && (outData !== prevOutData))
        protocolError("outData changed while outReq was high");
      if (outReq && !prevOutReq && prevOutAck)
        protocolError("outReq rose again before outAck had fallen");
      if (outReq && !prevOutReq && (expectQ.size() == 0))
        protocolError("outReq rose with no product outstanding");
      if (outAck && !prevOutAck)
        compareHead();
    end
    prevInReq = inReq;
    prevInAck = inAck;
    prevOutReq = outReq;
    prevOutAck = outAck;
    prevOutData = outData;
  end

endmodule

//--- resultBuffer.sv
// circular FIFO of finished products with a four-phase req/ack read side
// Depth must be 2 or more; outData is the entry at the read pointer and holds
// while outReq is high, and outReq only rises again after outAck has fallen
`timescale 1ns/1ps

module resultBuffer
  import mulTypesPkg::*;
#(
  parameter int Width,
  parameter int Depth
) (
  input  logic    CLk,
  input  logic    reset,
  input  logic    pushValid,
  input  result_t pushData,
  input  logic    outAck,
  output logic    full,
  output logic    outReq,
  output result_t outData
);

  localparam int PtrW = $clog2(Depth);
  localparam int CountW = $clog2(Depth + 1);
  localparam logic [PtrW-1:0] LastIdx = PtrW'(Depth - 1);
  // the one product that needs every bit, 2**(2*Width-2)
  localparam logic [2*DefaultWidth-1:0] FullWidthValue =
    (2*DefaultWidth)'(1) << (2*Width - 2);

  result_t mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CountW-1:0] count;
  logic pop;

  assign full = (count == CountW'(Depth));
  assign pop = outReq && outAck;  // consumer has taken the head
  assign outData = mem[rdPtr];

  always_ff @(posedge CLk)
  begin
    if (pushValid)
      mem[wrPtr] <= pushData;
  end

  always_ff @(posedge CLk)
  begin
    if (reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      outReq <= 1'b0;
    end
    else
    begin
      if (pushValid)
        wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + PtrW'(1);
      if (pop)
        rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + PtrW'(1);

      unique case ({pushValid, pop})
        2'b10: count <= count + CountW'(1);
        2'b01: count <= count - CountW'(1);
        default: count <= count;  // none, or one in and one out
      endcase

      // drop after the pop; raise only when ack has returned to zero
      if (pop)
        outReq <= 1'b0;
      else if (!outReq && !outAck && ((count != '0) || pushValid))
        outReq <= 1'b1;
    end
  end

  noPushWhileFull: assert property (@(posedge CLk) disable iff (reset)
    pushValid |-> !full)
    else $error("push into full result buffer");

  // flag from the datapath must agree with the value it marks
  flagMatchesValue: assert property (@(posedge CLk) disable iff (reset)
    (pushValid && pushData.fullWidth) |-> (pushData.product.word == FullWidthValue))
    else $error("full-width flag set on a product that does not need it");

endmodule
